// ==== src/rvPkg.sv ====
package rvPkg;

    localparam int xlen          = 32;
    localparam int regAddrW      = 5;
    localparam int imemDepthLog2 = 8;
    localparam int dmemDepthLog2 = 8;

    // Base opcodes of the supported subset
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;

    // Operand source picked by forwarding
    localparam logic [1:0] fwdReg = 2'b00;
    localparam logic [1:0] fwdWb  = 2'b01;
    localparam logic [1:0] fwdMem = 2'b10;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt} aluOp_t;

    typedef enum logic [1:0] {resAlu, resLoad, resPc4} resultSel_t;

    typedef struct packed {
        logic [6:0]          funct7;
        logic [regAddrW-1:0] rs2;
        logic [regAddrW-1:0] rs1;
        logic [2:0]          funct3;
        logic [regAddrW-1:0] rd;
        logic [6:0]          opcode;
    } rFormat_t;

    typedef struct packed {
        logic [11:0]         imm;
        logic [regAddrW-1:0] rs1;
        logic [2:0]          funct3;
        logic [regAddrW-1:0] rd;
        logic [6:0]          opcode;
    } iFormat_t;

    typedef struct packed {
        logic [6:0]          immHi;
        logic [regAddrW-1:0] rs2;
        logic [regAddrW-1:0] rs1;
        logic [2:0]          funct3;
        logic [4:0]          immLo;
        logic [6:0]          opcode;
    } sFormat_t;

    // One instruction word, three field layouts
    typedef union packed {
        rFormat_t rFormat;
        iFormat_t iFormat;
        sFormat_t sFormat;
    } instrWord_t;

endpackage

// ==== src/instrMemory.sv ====
`timescale 1ns/1ps

module instrMemory (
    input  logic                            clk,
    input  logic                            bootWe,
    input  logic [rvPkg::imemDepthLog2-1:0] bootAddr,
    input  logic [rvPkg::xlen-1:0]          bootData,
    input  logic [rvPkg::xlen-1:0]          pc,
    output logic [rvPkg::xlen-1:0]          instr
);
    import rvPkg::*;

    logic [xlen-1:0] mem [2**imemDepthLog2];

    // Program is loaded one word per edge while the core is idle
    always_ff @(posedge clk) begin
        if (bootWe) begin
            mem[bootAddr] <= bootData;
        end
    end

    // PC is a byte address
    assign instr = mem[pc[imemDepthLog2+1:2]];

endmodule

// ==== src/decoder.sv ====
`timescale 1ns/1ps

module decoder (
    input  rvPkg::instrWord_t      instr,
    output logic                   regWrite,
    output logic                   memWrite,
    output rvPkg::resultSel_t      resultSel,
    output rvPkg::aluOp_t          aluOp,
    output logic                   aluSrcImm,
    output logic                   branch,
    output logic                   branchNe,
    output logic                   jump,
    output logic [rvPkg::xlen-1:0] imm
);
    import rvPkg::*;

    logic [xlen-1:0] iImm;
    logic [xlen-1:0] sImm;
    logic [xlen-1:0] bImm;
    logic [xlen-1:0] jImm;
    aluOp_t          arithOp;
    logic            arithOk;

    assign iImm = {{20{instr.iFormat.imm[11]}}, instr.iFormat.imm};
    assign sImm = {{20{instr.sFormat.immHi[6]}}, instr.sFormat.immHi, instr.sFormat.immLo};

    // B immediate reuses the S fields, bit 11 sits in immLo[0]
    assign bImm = {{20{instr.sFormat.immHi[6]}}, instr.sFormat.immLo[0],
                   instr.sFormat.immHi[5:0], instr.sFormat.immLo[4:1], 1'b0};

    // J immediate spans the I view's imm, rs1 and funct3 fields
    assign jImm = {{12{instr.iFormat.imm[11]}}, instr.iFormat.rs1, instr.iFormat.funct3,
                   instr.iFormat.imm[0], instr.iFormat.imm[10:1], 1'b0};

    // funct3 meaning shared by OP and OP-IMM
    always_comb begin
        arithOk = 1'b1;
        case (instr.rFormat.funct3)
            3'b000:  arithOp = aluAdd;
            3'b010:  arithOp = aluSlt;
            3'b100:  arithOp = aluXor;
            3'b110:  arithOp = aluOr;
            3'b111:  arithOp = aluAnd;
            default: begin
                arithOp = aluAdd;
                arithOk = 1'b0;
            end
        endcase
    end

    always_comb begin
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        resultSel = resAlu;
        aluOp     = aluAdd;
        aluSrcImm = 1'b0;
        branch    = 1'b0;
        branchNe  = 1'b0;
        jump      = 1'b0;
        imm       = iImm;
        case (instr.rFormat.opcode)
            opOp: begin
                regWrite = arithOk;
                // SUB is the only funct7 variant kept
                if (arithOp == aluAdd && instr.rFormat.funct7[5]) begin
                    aluOp = aluSub;
                end else begin
                    aluOp = arithOp;
                end
            end
            opOpImm: begin
                regWrite  = arithOk;
                aluOp     = arithOp;
                aluSrcImm = 1'b1;
            end
            opLoad: begin
                regWrite  = 1'b1;
                resultSel = resLoad;
                aluSrcImm = 1'b1;
            end
            opStore: begin
                memWrite  = 1'b1;
                aluSrcImm = 1'b1;
                imm       = sImm;
            end
            opBranch: begin
                // BEQ and BNE only
                branch   = (instr.rFormat.funct3[2:1] == 2'b00);
                branchNe = instr.rFormat.funct3[0];
                imm      = bImm;
            end
            opJal: begin
                regWrite  = 1'b1;
                resultSel = resPc4;
                jump      = 1'b1;
                imm       = jImm;
            end
            default: ;
        endcase
    end

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [rvPkg::regAddrW-1:0] rs1,
    input  logic [rvPkg::regAddrW-1:0] rs2,
    input  logic [rvPkg::regAddrW-1:0] rd,
    input  logic                       we,
    input  logic [rvPkg::xlen-1:0]     wd,
    output logic [rvPkg::xlen-1:0]     rd1,
    output logic [rvPkg::xlen-1:0]     rd2,
    output logic [rvPkg::xlen-1:0]     a0
);
    import rvPkg::*;

    logic [xlen-1:0] regs [2**regAddrW];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 2**regAddrW; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    // Write-first so decode sees the value written back this cycle
    function automatic logic [xlen-1:0] readPort(input logic [regAddrW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (we && addr == rd) begin
            return wd;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rd1 = readPort(rs1);
        rd2 = readPort(rs2);
    end

    assign a0 = regs[10];

endmodule

// ==== src/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
    input  logic [rvPkg::regAddrW-1:0] rs1D,
    input  logic [rvPkg::regAddrW-1:0] rs2D,
    input  logic [rvPkg::regAddrW-1:0] rs1E,
    input  logic [rvPkg::regAddrW-1:0] rs2E,
    input  logic [rvPkg::regAddrW-1:0] rdE,
    input  logic [rvPkg::regAddrW-1:0] rdM,
    input  logic [rvPkg::regAddrW-1:0] rdW,
    input  logic                       memReadE,
    input  logic                       regWriteM,
    input  logic                       regWriteW,
    input  logic                       redirectE,
    output logic [1:0]                 forwardA,
    output logic [1:0]                 forwardB,
    output logic                       stall,
    output logic                       flush
);
    import rvPkg::*;

    // Youngest producer wins, x0 never forwards
    function automatic logic [1:0] pickSource(input logic [regAddrW-1:0] src);
        if (src == '0) begin
            return fwdReg;
        end else if (regWriteM && src == rdM) begin
            return fwdMem;
        end else if (regWriteW && src == rdW) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    always_comb begin
        forwardA = pickSource(rs1E);
        forwardB = pickSource(rs2E);
    end

    // Load data is only ready after memory, so hold decode one cycle
    assign stall = memReadE && (rdE == rs1D || rdE == rs2D);

    assign flush = redirectE;

endmodule

// ==== src/executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit (
    input  logic [rvPkg::xlen-1:0] rd1E,
    input  logic [rvPkg::xlen-1:0] rd2E,
    input  logic [rvPkg::xlen-1:0] aluResultM,
    input  logic [rvPkg::xlen-1:0] resultW,
    input  logic [rvPkg::xlen-1:0] immE,
    input  logic [rvPkg::xlen-1:0] pcE,
    input  logic [1:0]             forwardA,
    input  logic [1:0]             forwardB,
    input  rvPkg::aluOp_t          aluOp,
    input  logic                   aluSrcImm,
    input  logic                   branch,
    input  logic                   branchNe,
    input  logic                   jump,
    output logic [rvPkg::xlen-1:0] aluResult,
    output logic [rvPkg::xlen-1:0] storeData,
    output logic                   redirect,
    output logic [rvPkg::xlen-1:0] target
);
    import rvPkg::*;

    logic [xlen-1:0] srcA;
    logic [xlen-1:0] srcB;
    logic            equal;

    function automatic logic [xlen-1:0] pickOperand(
        input logic [1:0]      sel,
        input logic [xlen-1:0] regVal,
        input logic [xlen-1:0] memVal,
        input logic [xlen-1:0] wbVal
    );
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign srcA      = pickOperand(forwardA, rd1E, aluResultM, resultW);
    assign storeData = pickOperand(forwardB, rd2E, aluResultM, resultW);
    assign srcB      = aluSrcImm ? immE : storeData;

    always_comb begin
        case (aluOp)
            aluSub:  aluResult = srcA - srcB;
            aluAnd:  aluResult = srcA & srcB;
            aluOr:   aluResult = srcA | srcB;
            aluXor:  aluResult = srcA ^ srcB;
            aluSlt:  aluResult = {{(xlen-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            default: aluResult = srcA + srcB;
        endcase
    end

    // Branches compare the two register operands, never the immediate
    assign equal    = (srcA == storeData);
    assign redirect = (branch && (equal ^ branchNe)) || jump;
    assign target   = pcE + immE;

endmodule

// ==== src/dataMemory.sv ====
`timescale 1ns/1ps

module dataMemory (
    input  logic                   clk,
    input  logic                   we,
    input  logic [rvPkg::xlen-1:0] addr,
    input  logic [rvPkg::xlen-1:0] wd,
    output logic [rvPkg::xlen-1:0] rd
);
    import rvPkg::*;

    logic [xlen-1:0]          mem [2**dmemDepthLog2];
    logic [dmemDepthLog2-1:0] index;

    // Word accesses only, byte offset dropped
    assign index = addr[dmemDepthLog2+1:2];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wd;
        end
    end

    assign rd = mem[index];

endmodule

// ==== src/rvCore.sv ====
`timescale 1ns/1ps

module rvCore (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            run,
    input  logic                            bootWe,
    input  logic [rvPkg::imemDepthLog2-1:0] bootAddr,
    input  logic [rvPkg::xlen-1:0]          bootData,
    output logic                            retireValid,
    output logic [rvPkg::regAddrW-1:0]      retireRd,
    output logic [rvPkg::xlen-1:0]          retireData,
    output logic [rvPkg::xlen-1:0]          a0
);
    import rvPkg::*;

    // Fetch
    logic [xlen-1:0]     pcF;
    logic [xlen-1:0]     instrF;

    // Decode
    instrWord_t          instrD;
    logic [xlen-1:0]     pcD;
    logic                regWriteD;
    logic                memWriteD;
    resultSel_t          resultSelD;
    aluOp_t              aluOpD;
    logic                aluSrcImmD;
    logic                branchD;
    logic                branchNeD;
    logic                jumpD;
    logic [xlen-1:0]     immD;
    logic [xlen-1:0]     rd1D;
    logic [xlen-1:0]     rd2D;

    // Execute
    logic                regWriteE;
    logic                memWriteE;
    resultSel_t          resultSelE;
    aluOp_t              aluOpE;
    logic                aluSrcImmE;
    logic                branchE;
    logic                branchNeE;
    logic                jumpE;
    logic [xlen-1:0]     rd1E;
    logic [xlen-1:0]     rd2E;
    logic [xlen-1:0]     immE;
    logic [xlen-1:0]     pcE;
    logic [regAddrW-1:0] rs1E;
    logic [regAddrW-1:0] rs2E;
    logic [regAddrW-1:0] rdE;
    logic [xlen-1:0]     aluResultE;
    logic [xlen-1:0]     storeDataE;
    logic [xlen-1:0]     targetE;
    logic                redirectE;
    logic [1:0]          forwardA;
    logic [1:0]          forwardB;
    logic                stall;
    logic                flush;

    // Memory
    logic                regWriteM;
    logic                memWriteM;
    resultSel_t          resultSelM;
    logic [xlen-1:0]     aluResultM;
    logic [xlen-1:0]     storeDataM;
    logic [xlen-1:0]     pcPlus4M;
    logic [xlen-1:0]     readDataM;
    logic [regAddrW-1:0] rdM;

    // Write-back
    logic                regWriteW;
    resultSel_t          resultSelW;
    logic [xlen-1:0]     aluResultW;
    logic [xlen-1:0]     readDataW;
    logic [xlen-1:0]     pcPlus4W;
    logic [xlen-1:0]     resultW;
    logic [regAddrW-1:0] rdW;

    // PC holds at zero until run, redirect beats the sequential step
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcF <= '0;
        end else if (!run) begin
            pcF <= '0;
        end else if (redirectE) begin
            pcF <= targetE;
        end else if (!stall) begin
            pcF <= pcF + 32'd4;
        end
    end

    instrMemory i_imem (
        .clk      (clk),
        .bootWe   (bootWe),
        .bootAddr (bootAddr),
        .bootData (bootData),
        .pc       (pcF),
        .instr    (instrF)
    );

    // An all-zero word decodes as a bubble
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            instrD <= '0;
        end else if (!run || flush) begin
            instrD <= '0;
        end else if (!stall) begin
            instrD <= instrF;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pcD <= pcF;
        end
    end

    decoder i_decoder (
        .instr     (instrD),
        .regWrite  (regWriteD),
        .memWrite  (memWriteD),
        .resultSel (resultSelD),
        .aluOp     (aluOpD),
        .aluSrcImm (aluSrcImmD),
        .branch    (branchD),
        .branchNe  (branchNeD),
        .jump      (jumpD),
        .imm       (immD)
    );

    regFile i_regFile (
        .clk  (clk),
        .rstN (rstN),
        .rs1  (instrD.rFormat.rs1),
        .rs2  (instrD.rFormat.rs2),
        .rd   (rdW),
        .we   (regWriteW),
        .wd   (resultW),
        .rd1  (rd1D),
        .rd2  (rd2D),
        .a0   (a0)
    );

    hazardUnit i_hazard (
        .rs1D      (instrD.rFormat.rs1),
        .rs2D      (instrD.rFormat.rs2),
        .rs1E      (rs1E),
        .rs2E      (rs2E),
        .rdE       (rdE),
        .rdM       (rdM),
        .rdW       (rdW),
        .memReadE  (resultSelE == resLoad),
        .regWriteM (regWriteM),
        .regWriteW (regWriteW),
        .redirectE (redirectE),
        .forwardA  (forwardA),
        .forwardB  (forwardB),
        .stall     (stall),
        .flush     (flush)
    );

    // Stall or flush turns the execute slot into a bubble
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteE  <= 1'b0;
            memWriteE  <= 1'b0;
            resultSelE <= resAlu;
            aluOpE     <= aluAdd;
            aluSrcImmE <= 1'b0;
            branchE    <= 1'b0;
            branchNeE  <= 1'b0;
            jumpE      <= 1'b0;
        end else begin
            regWriteE  <= regWriteD && !(stall || flush);
            memWriteE  <= memWriteD && !(stall || flush);
            resultSelE <= (stall || flush) ? resAlu : resultSelD;
            aluOpE     <= aluOpD;
            aluSrcImmE <= aluSrcImmD;
            branchE    <= branchD && !(stall || flush);
            branchNeE  <= branchNeD;
            jumpE      <= jumpD && !(stall || flush);
        end
    end

    always_ff @(posedge clk) begin
        rd1E <= rd1D;
        rd2E <= rd2D;
        immE <= immD;
        pcE  <= pcD;
        rs1E <= instrD.rFormat.rs1;
        rs2E <= instrD.rFormat.rs2;
        rdE  <= instrD.rFormat.rd;
    end

    executeUnit i_execute (
        .rd1E       (rd1E),
        .rd2E       (rd2E),
        .aluResultM (aluResultM),
        .resultW    (resultW),
        .immE       (immE),
        .pcE        (pcE),
        .forwardA   (forwardA),
        .forwardB   (forwardB),
        .aluOp      (aluOpE),
        .aluSrcImm  (aluSrcImmE),
        .branch     (branchE),
        .branchNe   (branchNeE),
        .jump       (jumpE),
        .aluResult  (aluResultE),
        .storeData  (storeDataE),
        .redirect   (redirectE),
        .target     (targetE)
    );

    // Execute to memory, then memory to write-back
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteM  <= 1'b0;
            memWriteM  <= 1'b0;
            resultSelM <= resAlu;
            regWriteW  <= 1'b0;
            resultSelW <= resAlu;
        end else begin
            regWriteM  <= regWriteE;
            memWriteM  <= memWriteE;
            resultSelM <= resultSelE;
            regWriteW  <= regWriteM;
            resultSelW <= resultSelM;
        end
    end

    always_ff @(posedge clk) begin
        aluResultM <= aluResultE;
        storeDataM <= storeDataE;
        pcPlus4M   <= pcE + 32'd4;
        rdM        <= rdE;
        aluResultW <= aluResultM;
        readDataW  <= readDataM;
        pcPlus4W   <= pcPlus4M;
        rdW        <= rdM;
    end

    dataMemory i_dmem (
        .clk  (clk),
        .we   (memWriteM),
        .addr (aluResultM),
        .wd   (storeDataM),
        .rd   (readDataM)
    );

    always_comb begin
        case (resultSelW)
            resLoad: resultW = readDataW;
            resPc4:  resultW = pcPlus4W;
            default: resultW = aluResultW;
        endcase
    end

    // Writes to x0 are architecturally invisible
    assign retireValid = regWriteW && (rdW != '0);
    assign retireRd    = rdW;
    assign retireData  = resultW;

endmodule

// ==== verif/pipeline_chk.sv ====
`timescale 1ns/1ps

module pipelineChk (
    input logic                   clk,
    input logic                   rstN,
    input logic                   run,
    input logic                   stall,
    input logic                   flush,
    input logic [rvPkg::xlen-1:0] pcF,
    input logic                   regWriteW,
    input logic                   memWriteM
);
    int assertFails = 0;

    // Reset must keep every write port quiet
    noWriteInReset: assert property (@(posedge clk) !rstN |-> !(regWriteW || memWriteM))
        else begin
            $error("register or memory write while reset is held");
            assertFails++;
        end

    // A load and a redirect never share the execute stage
    noStallWithFlush: assert property (@(posedge clk) disable iff (!rstN) !(stall && flush))
        else begin
            $error("stall and flush raised in the same cycle");
            assertFails++;
        end

    stallHoldsFetch: assert property (@(posedge clk) disable iff (!rstN)
                                      stall && run |=> $stable(pcF))
        else begin
            $error("fetch PC moved during a load-use stall");
            assertFails++;
        end

endmodule

bind rvCore pipelineChk i_chk (
    .clk       (clk),
    .rstN      (rstN),
    .run       (run),
    .stall     (stall),
    .flush     (flush),
    .pcF       (pcF),
    .regWriteW (regWriteW),
    .memWriteM (memWriteM)
);

// ==== verif/tbCore.sv ====
`timescale 1ns/1ps

module tbCore;
    import rvPkg::*;

    localparam int numProgs       = 20;
    localparam int progLen        = 40;
    localparam int clkPeriod      = 4;
    localparam int quietLimit     = 20;
    localparam int watchdogCycles = numProgs * (3 * progLen + 50);

    // Kinds 0..5 are R-type, 6..10 are I-type in the same funct order
    localparam int kLw  = 11;
    localparam int kSw  = 12;
    localparam int kBeq = 13;
    localparam int kBne = 14;
    localparam int kJal = 15;

    logic                     clk;
    logic                     rstN;
    logic                     run;
    logic                     bootWe;
    logic [imemDepthLog2-1:0] bootAddr;
    logic [xlen-1:0]          bootData;
    logic                     retireValid;
    logic [regAddrW-1:0]      retireRd;
    logic [xlen-1:0]          retireData;
    logic [xlen-1:0]          a0;

    logic [31:0] lcgState;
    int          errors;
    int          kind [progLen];
    logic [4:0]  fRd [progLen];
    logic [4:0]  fRs1 [progLen];
    logic [4:0]  fRs2 [progLen];
    logic [31:0] fImm [progLen];
    logic [31:0] words [progLen];
    // Survives across programs, like the core's data store
    logic [31:0] dmemModel [256];
    logic [4:0]  expRd [$];
    logic [31:0] expData [$];
    logic [31:0] expA0;

    rvCore i_dut (
        .clk         (clk),
        .rstN        (rstN),
        .run         (run),
        .bootWe      (bootWe),
        .bootAddr    (bootAddr),
        .bootData    (bootData),
        .retireValid (retireValid),
        .retireRd    (retireRd),
        .retireData  (retireData),
        .a0          (a0)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // Halves swapped so the weak low bits land on top
    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return {lcgState[15:0], lcgState[31:16]};
    endfunction

    // x0..x11 only, so operands collide often
    function automatic logic [4:0] pickReg();
        logic [31:0] r;
        r = nextRand() % 32'd12;
        return r[4:0];
    endfunction

    function automatic logic [2:0] arithFunct3(input int k);
        case (k)
            2, 7:    return 3'b111;
            3, 8:    return 3'b110;
            4, 9:    return 3'b100;
            5, 10:   return 3'b010;
            default: return 3'b000;
        endcase
    endfunction

    function automatic logic [31:0] aluModel(input int k, input logic [31:0] a,
                                             input logic [31:0] b);
        case (k)
            1:       return a - b;
            2, 7:    return a & b;
            3, 8:    return a | b;
            4, 9:    return a ^ b;
            5, 10:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return a + b;
        endcase
    endfunction

    // RV32I base encodings
    function automatic logic [31:0] encode(input int i);
        logic [31:0] m;
        m = fImm[i];
        if (kind[i] <= 5) begin
            return {(kind[i] == 1) ? 7'h20 : 7'h00, fRs2[i], fRs1[i],
                    arithFunct3(kind[i]), fRd[i], 7'b0110011};
        end else if (kind[i] <= 10) begin
            return {m[11:0], fRs1[i], arithFunct3(kind[i]), fRd[i], 7'b0010011};
        end else if (kind[i] == kLw) begin
            return {m[11:0], 5'd0, 3'b010, fRd[i], 7'b0000011};
        end else if (kind[i] == kSw) begin
            return {m[11:5], fRs2[i], 5'd0, 3'b010, m[4:0], 7'b0100011};
        end else if (kind[i] == kJal) begin
            return {m[20], m[10:1], m[11], m[19:12], fRd[i], 7'b1101111};
        end
        return {m[12], m[10:5], fRs2[i], fRs1[i], 2'b00, kind[i] == kBne,
                m[4:1], m[11], 7'b1100011};
    endfunction

    task automatic genProgram(input int p);
        logic [31:0] r;
        int          span;
        for (int i = 0; i < progLen; i++) begin
            kind[i] = int'(nextRand() % 32'd16);
            fRd[i]  = pickReg();
            fRs1[i] = pickReg();
            fRs2[i] = (nextRand() % 32'd4 == 0) ? fRs1[i] : pickReg();
            r       = nextRand();
            fImm[i] = {{20{r[11]}}, r[11:0]};
            if (p == 0 && i < 8) begin
                // Seed every data slot before any load can see it
                kind[i] = kSw;
                fRs2[i] = '0;
                fImm[i] = 32'(i) * 32'd132;
            end else if (i == progLen - 1) begin
                kind[i] = kJal;
                fRd[i]  = '0;
                fImm[i] = '0;
            end else if (kind[i] == kLw || kind[i] == kSw) begin
                fRs1[i] = '0;
                fImm[i] = (nextRand() % 32'd8) * 32'd132;
            end else if (kind[i] >= kBeq) begin
                span    = (progLen - 1 - i < 4) ? progLen - 1 - i : 4;
                fImm[i] = 32'd4 * (32'd1 + nextRand() % 32'(span));
            end
            words[i] = encode(i);
        end
    endtask

    // Runs until the closing self loop and queues each visible write
    task automatic runModel();
        logic [31:0] regs [32];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        int          pc;
        int          next;
        bit          wr;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        expRd.delete();
        expData.delete();
        pc = 0;
        while (pc < progLen - 1) begin
            a    = regs[fRs1[pc]];
            b    = regs[fRs2[pc]];
            v    = '0;
            wr   = 1'b1;
            next = pc + 1;
            case (kind[pc])
                kLw: v = dmemModel[fImm[pc][9:2]];
                kSw: begin
                    dmemModel[fImm[pc][9:2]] = b;
                    wr = 1'b0;
                end
                kBeq, kBne: begin
                    wr = 1'b0;
                    if ((a == b) != (kind[pc] == kBne)) begin
                        next = pc + int'(fImm[pc] >> 2);
                    end
                end
                kJal: begin
                    v    = 32'((pc + 1) * 4);
                    next = pc + int'(fImm[pc] >> 2);
                end
                default: v = aluModel(kind[pc], a, (kind[pc] <= 5) ? b : fImm[pc]);
            endcase
            if (wr && fRd[pc] != '0) begin
                regs[fRd[pc]] = v;
                expRd.push_back(fRd[pc]);
                expData.push_back(v);
            end
            pc = next;
        end
        expA0 = regs[10];
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic sampleRetire(input int p, inout int seen);
        if (retireValid) begin
            if (expRd.size() == 0) begin
                $display("Program %0d retired a write to x%0d that the model never made",
                         p, retireRd);
                errors++;
            end else begin
                checkValue($sformatf("prog%0d retire%0d rd", p, seen),
                           32'(expRd.pop_front()), 32'(retireRd));
                checkValue($sformatf("prog%0d retire%0d data", p, seen),
                           expData.pop_front(), retireData);
            end
            seen++;
        end
    endtask

    task automatic runProgram(input int p);
        int quiet;
        int seen;
        genProgram(p);
        runModel();
        @(negedge clk);
        rstN = 1'b0;
        run  = 1'b0;
        repeat (5) @(negedge clk);
        rstN = 1'b1;
        for (int i = 0; i < progLen; i++) begin
            @(negedge clk);
            bootWe   = 1'b1;
            bootAddr = i[imemDepthLog2-1:0];
            bootData = words[i];
        end
        @(negedge clk);
        bootWe = 1'b0;
        run    = 1'b1;
        quiet  = 0;
        seen   = 0;
        // Outputs come from write-back registers, stable at the falling edge
        while (quiet < quietLimit) begin
            @(negedge clk);
            sampleRetire(p, seen);
            quiet = (expRd.size() == 0) ? quiet + 1 : 0;
        end
        checkValue($sformatf("prog%0d a0", p), expA0, a0);
        run = 1'b0;
    endtask

    initial begin
        clk      = 1'b0;
        rstN     = 1'b0;
        run      = 1'b0;
        bootWe   = 1'b0;
        bootAddr = '0;
        bootData = '0;
        errors   = 0;
        lcgState = 32'hbb2e_c081;
        for (int p = 0; p < numProgs; p++) begin
            runProgram(p);
        end
        $display("Errors: %0d compare, %0d assertion", errors, i_dut.i_chk.assertFails);
        if (errors == 0 && i_dut.i_chk.assertFails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("Timeout: the core hung, retire events stopped before %0d cycles were up",
                 watchdogCycles);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== sources.f ====
src/rvPkg.sv
src/instrMemory.sv
src/decoder.sv
src/regFile.sv
src/hazardUnit.sv
src/executeUnit.sv
src/dataMemory.sv
src/rvCore.sv
verif/pipeline_chk.sv
verif/tbCore.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbCore -f sources.f

# Raise the error limit so assertion failures reach the closing report
out=$(./obj_dir/VtbCore +verilator+error+limit+1000 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
